//--- mem_pkg.sv
/* shared types and sizing constants for the two-bank memory model
   address, block, tag and command types plus size and latency values */

package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] ADDR;      // processor byte address
    typedef logic [63:0] MEM_BLOCK; // one 8-byte block
    typedef logic [3:0]  MEM_TAG;   // global tag, 0 means none or refused
    typedef logic [2:0]  BANK_TAG;  // bank-local tag, 0 means none

    // processor command encoding
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_command_t;

    //////////////////////////////////////////////////////////////////////
    // sizing
    //////////////////////////////////////////////////////////////////////

    localparam int MEM_SIZE_IN_BYTES     = 2048;  // 256 blocks in total
    localparam int BANK_LINES            = 128;   // blocks held by each bank
    localparam int NUM_BANK_TAGS         = 7;     // local tags 1..7 per bank
    localparam int MEM_LATENCY_IN_CYCLES = 4;     // fixed countdown per op

    // address bit that interleaves the two banks
    localparam int BANK_SEL_BIT = 3;

    // line index width inside a bank
    localparam int LINE_BITS = $clog2(BANK_LINES);

    // countdown width, must hold the full latency value
    localparam int CNT_BITS = $clog2(MEM_LATENCY_IN_CYCLES + 1);

endpackage

//--- mem_dispatch.sv
/* command dispatcher: address check, bank routing by address bit 3
   and merge of the bank accept tags into one global tag */

`timescale 1ns/1ps

module mem_dispatch (
    input  logic                          clock,
    input  logic                          rst_n,
    input  mem_pkg::ADDR                  proc2mem_addr,
    input  mem_pkg::MEM_BLOCK             proc2mem_data,
    input  mem_pkg::mem_command_t         proc2mem_command,
    input  mem_pkg::BANK_TAG              accept_tag_0,     // registered in bank 0
    input  mem_pkg::BANK_TAG              accept_tag_1,     // registered in bank 1
    output mem_pkg::mem_command_t         bank_command_0,
    output mem_pkg::mem_command_t         bank_command_1,
    output logic [mem_pkg::LINE_BITS-1:0] bank_line,
    output mem_pkg::MEM_BLOCK             bank_data,
    output mem_pkg::MEM_TAG               mem2proc_transaction_tag
);
    import mem_pkg::*;

    logic addr_ok;    // aligned and inside the memory
    logic bank_sel;   // bank picked for this cycle's command
    logic sel_q;      // bank that was addressed at the last edge

    //////////////////////////////////////////////////////////////////////
    // routing
    //////////////////////////////////////////////////////////////////////

    assign addr_ok  = (proc2mem_addr[2:0] == 3'b000) &&
                      (proc2mem_addr < ADDR'(MEM_SIZE_IN_BYTES));
    assign bank_sel = proc2mem_addr[BANK_SEL_BIT];

    // a bad address or an idle cycle leaves both banks idle
    always_comb begin
        bank_command_0 = MEM_NONE;
        bank_command_1 = MEM_NONE;
        if (addr_ok) begin
            if (bank_sel) begin
                bank_command_1 = proc2mem_command;
            end else begin
                bank_command_0 = proc2mem_command;
            end
        end
    end

    // block index inside the bank sits just above the bank bit
    assign bank_line = proc2mem_addr[BANK_SEL_BIT+LINE_BITS:BANK_SEL_BIT+1];
    assign bank_data = proc2mem_data;   // same payload to both banks

    //////////////////////////////////////////////////////////////////////
    // accept tag merge
    //////////////////////////////////////////////////////////////////////

    // remembers which bank the answering tag comes from
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= 1'b0;
        end else begin
            sel_q <= bank_sel;
        end
    end

    // bank 1 tags are offset by 8, a zero local tag stays zero
    always_comb begin
        mem2proc_transaction_tag = '0;
        if (sel_q) begin
            if (accept_tag_1 != '0) begin
                mem2proc_transaction_tag = {1'b1, accept_tag_1};
            end
        end else begin
            mem2proc_transaction_tag = {1'b0, accept_tag_0};
        end
    end

endmodule

//--- mem_bank.sv
/* one memory bank: block storage, seven tag slots with latency
   countdown, and the hold of finished loads toward the merger */

`timescale 1ns/1ps

module mem_bank (
    input  logic                          clock,
    input  logic                          rst_n,
    input  mem_pkg::mem_command_t         bank_command,
    input  logic [mem_pkg::LINE_BITS-1:0] bank_line,
    input  mem_pkg::MEM_BLOCK             bank_data,
    input  logic                          done_ready,   // merger takes done_* this edge
    output mem_pkg::BANK_TAG              accept_tag,   // 0 when refused or idle
    output logic                          done_valid,
    output mem_pkg::BANK_TAG              done_tag,
    output mem_pkg::MEM_BLOCK             done_data
);
    import mem_pkg::*;

    MEM_BLOCK            mem_array [BANK_LINES];          // bank storage
    logic [CNT_BITS-1:0] slot_cnt  [1:NUM_BANK_TAGS];     // cycles left per tag
    logic                slot_pend [1:NUM_BANK_TAGS];     // load data not yet handed off
    MEM_BLOCK            slot_data [1:NUM_BANK_TAGS];     // captured load data

    BANK_TAG lock_tag;    // slot held on done_* after a lost arbitration
    BANK_TAG free_tag;    // lowest free slot, 0 when full
    BANK_TAG ready_tag;   // lowest finished load, 0 when none
    logic    take_cmd;    // command gets a slot this edge
    logic    handshake;   // done_* accepted by the merger

    //////////////////////////////////////////////////////////////////////
    // slot search
    //////////////////////////////////////////////////////////////////////

    // walk downward so the lowest matching slot wins
    always_comb begin
        free_tag = '0;
        for (int i = NUM_BANK_TAGS; i >= 1; i--) begin
            if ((slot_cnt[i] == '0) && !slot_pend[i]) begin
                free_tag = BANK_TAG'(i);
            end
        end
    end

    always_comb begin
        ready_tag = '0;
        for (int i = NUM_BANK_TAGS; i >= 1; i--) begin
            if ((slot_cnt[i] == '0) && slot_pend[i]) begin
                ready_tag = BANK_TAG'(i);   // countdown done, data waiting
            end
        end
    end

    assign take_cmd = (bank_command != MEM_NONE) && (free_tag != '0);

    //////////////////////////////////////////////////////////////////////
    // completion side
    //////////////////////////////////////////////////////////////////////

    // a held slot keeps the bus steady even if a lower one finishes meanwhile
    assign done_tag   = (lock_tag != '0) ? lock_tag : ready_tag;
    assign done_valid = (done_tag != '0);
    assign done_data  = done_valid ? slot_data[done_tag] : '0;
    assign handshake  = done_valid && done_ready;

    //////////////////////////////////////////////////////////////////////
    // tag slots
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            accept_tag <= '0;
            lock_tag   <= '0;
            for (int i = 1; i <= NUM_BANK_TAGS; i++) begin
                slot_cnt[i]  <= '0;
                slot_pend[i] <= 1'b0;
            end
        end else begin
            accept_tag <= take_cmd ? free_tag : '0;   // answer visible for one cycle

            for (int i = 1; i <= NUM_BANK_TAGS; i++) begin
                if (slot_cnt[i] != '0) begin
                    slot_cnt[i] <= slot_cnt[i] - 1'b1;
                end
            end

            // slot is released only once the merger has the data
            if (handshake) begin
                slot_pend[done_tag] <= 1'b0;
                lock_tag            <= '0;
            end else begin
                lock_tag <= done_tag;   // stays 0 when nothing is offered
            end

            // a free slot never has pend set, so no clash with the handoff above
            if (take_cmd) begin
                slot_cnt[free_tag]  <= CNT_BITS'(MEM_LATENCY_IN_CYCLES);
                slot_pend[free_tag] <= (bank_command == MEM_LOAD);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // stores land at the accepting edge, refused stores are dropped
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BANK_LINES; i++) begin
                mem_array[i] <= '0;
            end
        end else if (take_cmd && (bank_command == MEM_STORE)) begin
            mem_array[bank_line] <= bank_data;
        end
    end

    // load data captured at acceptance, sees any store from an earlier edge
    always_ff @(posedge clock) begin
        if (take_cmd && (bank_command == MEM_LOAD)) begin
            slot_data[free_tag] <= mem_array[bank_line];
        end
    end

endmodule

//--- mem_return_merge.sv
/* return merger: round-robin grant between the two banks and the
   registered returned-data bus with its global tag */

`timescale 1ns/1ps

module mem_return_merge (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              done_valid_0,
    input  mem_pkg::BANK_TAG  done_tag_0,
    input  mem_pkg::MEM_BLOCK done_data_0,
    input  logic              done_valid_1,
    input  mem_pkg::BANK_TAG  done_tag_1,
    input  mem_pkg::MEM_BLOCK done_data_1,
    output logic              done_ready_0,
    output logic              done_ready_1,
    output mem_pkg::MEM_BLOCK mem2proc_data,
    output mem_pkg::MEM_TAG   mem2proc_data_tag   // 0 when nothing returns
);
    import mem_pkg::*;

    logic   prio_1;     // bank 1 wins a tie when set
    logic   both_req;   // both banks offer a load
    MEM_TAG win_tag;    // global tag of the granted load

    //////////////////////////////////////////////////////////////////////
    // arbitration
    //////////////////////////////////////////////////////////////////////

    assign both_req = done_valid_0 && done_valid_1;

    assign done_ready_0 = done_valid_0 && (!done_valid_1 || !prio_1);
    assign done_ready_1 = done_valid_1 && (!done_valid_0 || prio_1);

    // bank 1 tags sit in the upper half of the global range
    always_comb begin
        if (done_ready_0) begin
            win_tag = {1'b0, done_tag_0};
        end else if (done_ready_1) begin
            win_tag = {1'b1, done_tag_1};
        end else begin
            win_tag = '0;
        end
    end

    // priority only moves on a real conflict
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            prio_1 <= 1'b0;
        end else if (both_req) begin
            prio_1 <= ~prio_1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // return bus
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem2proc_data_tag <= '0;
        end else begin
            mem2proc_data_tag <= win_tag;   // one cycle pulse per returned load
        end
    end

    // data only meaningful alongside a nonzero tag
    always_ff @(posedge clock) begin
        if (done_ready_0) begin
            mem2proc_data <= done_data_0;
        end else if (done_ready_1) begin
            mem2proc_data <= done_data_1;
        end
    end

endmodule

//--- mem_system.sv
/* top level of the two-bank memory: dispatcher, bank_0, bank_1
   and the return merger */

`timescale 1ns/1ps

module mem_system (
    input  logic                  clock,
    input  logic                  rst_n,
    input  mem_pkg::ADDR          proc2mem_addr,
    input  mem_pkg::MEM_BLOCK     proc2mem_data,
    input  mem_pkg::mem_command_t proc2mem_command,
    output mem_pkg::MEM_TAG       mem2proc_transaction_tag,  // accept tag, one cycle
    output mem_pkg::MEM_BLOCK     mem2proc_data,
    output mem_pkg::MEM_TAG       mem2proc_data_tag
);
    import mem_pkg::*;

    // dispatcher to banks
    mem_command_t         bank_command_0;
    mem_command_t         bank_command_1;
    logic [LINE_BITS-1:0] bank_line;
    MEM_BLOCK             bank_data;
    BANK_TAG              accept_tag_0;
    BANK_TAG              accept_tag_1;

    // banks to merger
    logic     done_valid_0, done_valid_1;
    BANK_TAG  done_tag_0, done_tag_1;
    MEM_BLOCK done_data_0, done_data_1;
    logic     done_ready_0, done_ready_1;

    //////////////////////////////////////////////////////////////////////
    // command side
    //////////////////////////////////////////////////////////////////////

    mem_dispatch dispatch (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .proc2mem_command         (proc2mem_command),
        .accept_tag_0             (accept_tag_0),
        .accept_tag_1             (accept_tag_1),
        .bank_command_0           (bank_command_0),
        .bank_command_1           (bank_command_1),
        .bank_line                (bank_line),
        .bank_data                (bank_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag)
    );

    // even blocks
    mem_bank bank_0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .bank_command (bank_command_0),
        .bank_line    (bank_line),
        .bank_data    (bank_data),
        .done_ready   (done_ready_0),
        .accept_tag   (accept_tag_0),
        .done_valid   (done_valid_0),
        .done_tag     (done_tag_0),
        .done_data    (done_data_0)
    );

    // odd blocks
    mem_bank bank_1 (
        .clock        (clock),
        .rst_n        (rst_n),
        .bank_command (bank_command_1),
        .bank_line    (bank_line),
        .bank_data    (bank_data),
        .done_ready   (done_ready_1),
        .accept_tag   (accept_tag_1),
        .done_valid   (done_valid_1),
        .done_tag     (done_tag_1),
        .done_data    (done_data_1)
    );

    //////////////////////////////////////////////////////////////////////
    // return side
    //////////////////////////////////////////////////////////////////////

    mem_return_merge merge (
        .clock             (clock),
        .rst_n             (rst_n),
        .done_valid_0      (done_valid_0),
        .done_tag_0        (done_tag_0),
        .done_data_0       (done_data_0),
        .done_valid_1      (done_valid_1),
        .done_tag_1        (done_tag_1),
        .done_data_1       (done_data_1),
        .done_ready_0      (done_ready_0),
        .done_ready_1      (done_ready_1),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_data_tag (mem2proc_data_tag)
    );

endmodule

//--- tb_mem_system.sv
/* testbench for the two-bank memory: clock, reset, xorshift stimulus,
   reference model with tag tables, compare tasks and watchdog */

`timescale 1ns/1ps

module tb_mem_system;
    import mem_pkg::*;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 4;
    localparam int STIM_CYCLES  = 3000;
    localparam int DRAIN_CYCLES = 40;
    localparam int MIN_RETURN   = MEM_LATENCY_IN_CYCLES + 1;  // merger adds one register
    localparam int NUM_BLOCKS   = MEM_SIZE_IN_BYTES / 8;

    logic         clock;
    logic         rst_n;
    ADDR          proc2mem_addr;
    MEM_BLOCK     proc2mem_data;
    mem_command_t proc2mem_command;
    MEM_TAG       mem2proc_transaction_tag;
    MEM_BLOCK     mem2proc_data;
    MEM_TAG       mem2proc_data_tag;

    MEM_BLOCK     model_mem [NUM_BLOCKS];  // expected memory contents
    mem_command_t tag_kind  [16];          // MEM_NONE when the tag was never used
    int           tag_cycle [16];          // acceptance cycle per global tag
    MEM_BLOCK     tag_data  [16];          // expected load data per global tag

    ADDR          sent_addr;               // command sampled at the last edge
    MEM_BLOCK     sent_data;
    mem_command_t sent_cmd;

    logic [31:0] rng;
    int cyc;
    int mismatches;
    int failures;
    int loads_accepted;
    int stores_accepted;
    int loads_returned;

    mem_system uut (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .proc2mem_command         (proc2mem_command),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag)
    );

    initial clock = 1'b0;
    always #(PERIOD/2) clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a store holds its slot for the latency, a load until its data returns
    function automatic logic tag_busy(input int t);
        if (tag_kind[t] == MEM_LOAD) return 1'b1;
        if (tag_kind[t] == MEM_STORE && (cyc - tag_cycle[t]) <= MEM_LATENCY_IN_CYCLES) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int busy_tags(input logic bank);
        int n;
        int base;
        n = 0;
        base = bank ? 8 : 0;   // bank 1 owns tags 9..15
        for (int t = base + 1; t <= base + NUM_BANK_TAGS; t++) begin
            if (tag_busy(t)) n++;
        end
        return n;
    endfunction

    function automatic int pending_loads();
        int n;
        n = 0;
        for (int t = 0; t < 16; t++) begin
            if (tag_kind[t] == MEM_LOAD) n++;
        end
        return n;
    endfunction

    task automatic check_tag(input string name, input MEM_TAG got, input MEM_TAG exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_block(input string name, input MEM_BLOCK got, input MEM_BLOCK exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("ERROR at cycle %0d: %s", cyc, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_idle();
        proc2mem_command = MEM_NONE;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        ADDR a;
        rng = xorshift(rng);
        r = rng;
        case (r[2:0])
            3'd0, 3'd1:       proc2mem_command = MEM_NONE;
            3'd2, 3'd3, 3'd4: proc2mem_command = MEM_STORE;
            default:          proc2mem_command = MEM_LOAD;
        endcase
        a = {24'h0, r[7:3], 3'b000};                            // 32-block window
        if (r[11:8] == 4'h0) begin
            a = a | {29'h0, r[14:13], 1'b1};                   // unaligned
        end else if (r[11:8] == 4'h1) begin
            a = a | 32'h0000_0800 | {r[31:16], 16'h0};         // aliases a window block
        end
        proc2mem_addr = a;
        rng = xorshift(rng);
        proc2mem_data[63:32] = rng;
        rng = xorshift(rng);
        proc2mem_data[31:0] = rng;
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks against the model
    //////////////////////////////////////////////////////////////////////

    // accept tag for the command sampled at edge cyc
    task automatic check_accept();
        logic   valid;
        logic   bank;
        int     t;
        int     blk;
        MEM_TAG got;
        got   = mem2proc_transaction_tag;
        valid = (sent_cmd != MEM_NONE) && (sent_addr[2:0] == 3'b000) &&
                (sent_addr < ADDR'(MEM_SIZE_IN_BYTES));
        bank  = sent_addr[3];
        t     = int'(got);
        if (!valid || busy_tags(bank) >= NUM_BANK_TAGS) begin
            check_tag("mem2proc_transaction_tag", got, '0);   // rejected or bank full
        end else if (got == '0) begin
            report_failure($sformatf("command to bank %0d refused with a free tag", bank));
        end else if (got[3] != bank || got[2:0] == 3'b000) begin
            report_failure($sformatf("accept tag %h outside the range of bank %0d", got, bank));
        end else if (tag_busy(t)) begin
            report_failure($sformatf("accept tag %h reissued while still outstanding", got));
        end else begin
            blk = int'(sent_addr[10:3]);
            tag_kind[t]  = sent_cmd;
            tag_cycle[t] = cyc;
            if (sent_cmd == MEM_STORE) begin
                model_mem[blk] = sent_data;
                stores_accepted++;
            end else begin
                tag_data[t] = model_mem[blk];   // value at the moment of acceptance
                loads_accepted++;
            end
        end
    endtask

    task automatic check_return();
        int t;
        t = int'(mem2proc_data_tag);
        if (t != 0) begin
            if (tag_kind[t] == MEM_STORE) begin
                report_failure($sformatf("data tag %h returned for a store", t));
            end else if (tag_kind[t] != MEM_LOAD) begin
                report_failure($sformatf("data tag %h returned with no outstanding load", t));
            end else begin
                if (cyc - tag_cycle[t] < MIN_RETURN) begin
                    report_failure($sformatf("data tag %h returned %0d cycles after accept",
                                             t, cyc - tag_cycle[t]));
                end
                check_block("mem2proc_data", mem2proc_data, tag_data[t]);
                tag_kind[t] = MEM_NONE;
                loads_returned++;
            end
        end
    endtask

    // one clock: note what the edge sampled, drive the next command, check at negedge
    task automatic run_cycle(input logic active);
        @(posedge clock);
        cyc++;
        sent_addr = proc2mem_addr;
        sent_data = proc2mem_data;
        sent_cmd  = proc2mem_command;
        #5;
        if (active) drive_random();
        else drive_idle();
        @(negedge clock);
        check_accept();   // occupancy seen by the edge, before this cycle's return
        check_return();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int drain;
        rng = 32'h82ca;
        cyc = 0;
        mismatches = 0;
        failures = 0;
        loads_accepted = 0;
        stores_accepted = 0;
        loads_returned = 0;
        rst_n = 1'b0;
        drive_idle();
        for (int i = 0; i < NUM_BLOCKS; i++) model_mem[i] = '0;
        for (int t = 0; t < 16; t++) begin
            tag_kind[t]  = MEM_NONE;
            tag_cycle[t] = 0;
            tag_data[t]  = '0;
        end

        repeat (RESET_CYCLES) @(posedge clock);
        #5 rst_n = 1'b1;
        @(negedge clock);
        check_tag("mem2proc_transaction_tag", mem2proc_transaction_tag, '0);
        check_tag("mem2proc_data_tag", mem2proc_data_tag, '0);

        repeat (STIM_CYCLES) run_cycle(1'b1);
        repeat (2) run_cycle(1'b0);   // last command still gets its accept check
        drain = 0;
        while (pending_loads() != 0 && drain < DRAIN_CYCLES) begin
            run_cycle(1'b0);
            drain++;
        end
        if (pending_loads() != 0) begin
            report_failure($sformatf("%0d loads never completed", pending_loads()));
        end

        $display("errors: %0d mismatches, %0d other failures (%0d loads, %0d returned, %0d stores)",
                 mismatches, failures, loads_accepted, loads_returned, stores_accepted);
        if (mismatches + failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + STIM_CYCLES + DRAIN_CYCLES + 20) * PERIOD);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- compile.f
mem_pkg.sv
mem_dispatch.sv
mem_bank.sv
mem_return_merge.sv
mem_system.sv
tb_mem_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the two-bank memory testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_mem_system -f compile.f -o sim_mem_system

./obj_dir/sim_mem_system | tee "$LOG"

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
